//--- list.f
+incdir+design
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/mem_burst_model.sv
verif/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - design
    files:
      - design/icache_pkg.sv
      - design/icache_tag_array.sv
      - design/icache_data_array.sv
      - design/icache_ctrl.sv
      - design/icache_top.sv
      - target: test
        files:
          - verif/mem_burst_model.sv
          - verif/tb_icache.sv

//--- verif/tb_icache.sv
`include "icache_macros.svh"

module tb_icache;

    localparam int TIMEOUT_CYCLES = 200 * 30;

    logic                I_clk = 1'b0;
    logic                I_rst;
    icache_pkg::addr_t   cpu_addr;
    logic                cpu_req;
    logic                cpu_ready;
    icache_pkg::word_t   cpu_inst;
    logic                cpu_rvalid;
    icache_pkg::addr_t   mem_araddr;
    logic                mem_arvalid;
    logic                mem_arready;
    icache_pkg::mem_rd_t mem_rd;

    // golden tags, valid bits and expectations
    icache_pkg::tag_t    g_tag [2][`ICACHE_SETS];
    logic                g_valid [2][`ICACHE_SETS];
    icache_pkg::index_t  req_index;
    icache_pkg::tag_t    req_tag;
    logic                model_hit;
    logic                miss_pending;
    icache_pkg::word_t   exp_word;
    icache_pkg::addr_t   exp_line;

    integer seed;
    int err_count = 0;
    int n_tests = 0;
    int n_failed = 0;
    int n_accept = 0;
    int n_resp = 0;
    int cycles = 0;

    icache_top u_dut (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_addr    (cpu_addr),
        .cpu_req     (cpu_req),
        .cpu_ready   (cpu_ready),
        .cpu_inst    (cpu_inst),
        .cpu_rvalid  (cpu_rvalid),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rd      (mem_rd)
    );

    mem_burst_model #(.SEED(32'hc07)) u_mem (
        .I_clk   (I_clk),
        .araddr  (mem_araddr),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .rd      (mem_rd)
    );

    always #20 I_clk = ~I_clk;

    ////////////////////
    // golden model
    ////////////////////
    assign req_index = cpu_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign req_tag = cpu_addr[31 -: `ICACHE_TAG_BITS];
    assign model_hit = (g_valid[0][req_index] && g_tag[0][req_index] == req_tag)
                    || (g_valid[1][req_index] && g_tag[1][req_index] == req_tag);

    // install on miss acceptance, no other request gets in before the refill
    always @(posedge I_clk) begin
        if (I_rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                g_valid[0][s] <= 1'b0;
                g_valid[1][s] <= 1'b0;
            end
            miss_pending <= 1'b0;
        end else begin
            if (cpu_req && cpu_ready) begin
                n_accept <= n_accept + 1;
                exp_word <= {cpu_addr[31:2], 2'b00} ^ 32'h5a5a0000;
                if (!model_hit) begin
                    miss_pending <= 1'b1;
                    exp_line <= {cpu_addr[31:`ICACHE_OFFSET_BITS], 5'b0};
                    // way 1 only if way 0 full and way 1 empty
                    if (g_valid[0][req_index] && !g_valid[1][req_index]) begin
                        g_valid[1][req_index] <= 1'b1;
                        g_tag[1][req_index] <= req_tag;
                    end else begin
                        g_valid[0][req_index] <= 1'b1;
                        g_tag[0][req_index] <= req_tag;
                    end
                end
            end
            if (mem_arvalid && mem_arready) begin
                miss_pending <= 1'b0;
            end
            if (cpu_rvalid) begin
                n_resp <= n_resp + 1;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////
    a_reset: assert property (@(posedge I_clk) $fell(I_rst)
        |-> cpu_ready && !cpu_rvalid && !mem_arvalid)
        else begin
            err_count++;
            $display("mismatch at %0t: ready/rvalid/arvalid got %b%b%b, expected 100", $time,
                $sampled(cpu_ready), $sampled(cpu_rvalid), $sampled(mem_arvalid));
        end

    // hit answers one cycle later, stays open for the next request
    // and never goes to memory
    a_hit: assert property (@(posedge I_clk) disable iff (I_rst)
        cpu_req && cpu_ready && model_hit |=> cpu_rvalid && cpu_ready && !mem_arvalid)
        else begin
            err_count++;
            $display("mismatch at %0t: rvalid/ready/arvalid after hit got %b%b%b, expected 110",
                $time, $sampled(cpu_rvalid), $sampled(cpu_ready), $sampled(mem_arvalid));
        end

    a_miss: assert property (@(posedge I_clk) disable iff (I_rst)
        cpu_req && cpu_ready && !model_hit |=> mem_arvalid)
        else begin
            err_count++;
            $display("mismatch at %0t: arvalid after predicted miss got 0, expected 1", $time);
        end

    // one burst per miss, at the line base
    a_burst: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_arvalid |-> miss_pending && mem_araddr == exp_line)
        else begin
            err_count++;
            $display("mismatch at %0t: mem_araddr got %h, expected %h (pending %b)", $time,
                $sampled(mem_araddr), $sampled(exp_line), $sampled(miss_pending));
        end

    a_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else begin
            err_count++;
            $display("request dropped or changed at %0t while arready was low", $time);
        end

    a_word: assert property (@(posedge I_clk) disable iff (I_rst)
        cpu_rvalid |-> cpu_inst == exp_word)
        else begin
            err_count++;
            $display("mismatch at %0t: cpu_inst got %h, expected %h", $time,
                $sampled(cpu_inst), $sampled(exp_word));
        end

    // run limit
    always @(posedge I_clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    function automatic icache_pkg::addr_t make_addr(input icache_pkg::tag_t t,
                                                    input icache_pkg::index_t i,
                                                    input logic [2:0] w);
        return {t, i, w, 2'b00};
    endfunction

    // called on a falling edge, returns one falling edge after acceptance
    task automatic fetch(input icache_pkg::addr_t a);
        cpu_addr = a;
        cpu_req = 1'b1;
        while (!cpu_ready) begin
            @(negedge I_clk);
        end
        @(negedge I_clk);
        cpu_req = 1'b0;
    endtask

    // back in IDLE, nothing outstanding
    task automatic drain();
        while (!cpu_ready || cpu_rvalid) begin
            @(negedge I_clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (err_count == errs_before) begin
            $display("test %-12s ok", name);
        end else begin
            n_failed++;
            $display("test %-12s %0d errors", name, err_count - errs_before);
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        int mark;
        int t_sel;
        int s_sel;
        int w_sel;
        seed = 32'hc07;
        cpu_addr = '0;
        cpu_req = 1'b0;
        I_rst = 1'b1;
        repeat (2) @(negedge I_clk);
        I_rst = 1'b0;

        mark = err_count;
        repeat (2) @(negedge I_clk);
        report_test("reset", mark);

        mark = err_count;
        fetch(make_addr(21'h1, 6'd3, 3'd5));
        drain();
        report_test("cold_miss", mark);

        // same word, then a back-to-back run through the line
        mark = err_count;
        fetch(make_addr(21'h1, 6'd3, 3'd5));
        for (int w = 0; w < 8; w++) begin
            fetch(make_addr(21'h1, 6'd3, w[2:0]));
        end
        drain();
        report_test("hit", mark);

        // set 9, two residents then a third tag
        mark = err_count;
        fetch(make_addr(21'h2, 6'd9, 3'd0));
        fetch(make_addr(21'h3, 6'd9, 3'd1));
        fetch(make_addr(21'h2, 6'd9, 3'd2));
        fetch(make_addr(21'h3, 6'd9, 3'd3));
        fetch(make_addr(21'h4, 6'd9, 3'd4));
        fetch(make_addr(21'h2, 6'd9, 3'd5));
        fetch(make_addr(21'h3, 6'd9, 3'd6));
        drain();
        report_test("replace", mark);

        // misses with random arready delay and beat gaps
        mark = err_count;
        for (int t = 0; t < 6; t++) begin
            fetch(make_addr(21'h10 + t, 6'd17, t[2:0] + 3'd1));
        end
        drain();
        report_test("backpressure", mark);

        // 8 sets, 4 tags each
        mark = err_count;
        for (int n = 0; n < 150; n++) begin
            t_sel = {$random(seed)} % 4;
            s_sel = {$random(seed)} % 8;
            w_sel = {$random(seed)} % 8;
            fetch(make_addr(21'h40 + t_sel, 6'd32 + s_sel, w_sel[2:0]));
        end
        drain();
        if (n_resp != n_accept) begin
            err_count++;
            $display("%0d responses seen for %0d accepted requests", n_resp, n_accept);
        end
        report_test("random", mark);

        $display("summary: %0d tests, %0d failed, %0d errors, %0d requests",
            n_tests, n_failed, err_count, n_accept);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/mem_burst_model.sv
`include "icache_macros.svh"

module mem_burst_model #(
    parameter int SEED = 32'hc07
) (
    input  logic                 I_clk,
    input  icache_pkg::addr_t    araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output icache_pkg::mem_rd_t  rd
);

    integer            seed;
    icache_pkg::addr_t base;

    // every word carries its own byte address, scrambled
    function automatic icache_pkg::word_t word_at(input icache_pkg::addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    ////////////////////
    // burst responder
    ////////////////////
    // all outputs change on the falling edge
    initial begin
        seed = SEED;
        arready = 1'b0;
        rd = '0;
        forever begin
            @(negedge I_clk);
            if (arvalid) begin
                // address accept after 0 to 3 cycles
                repeat ({$random(seed)} % 4) @(negedge I_clk);
                arready = 1'b1;
                base = araddr;
                @(negedge I_clk);
                arready = 1'b0;
                for (int b = 0; b < `ICACHE_BEATS; b++) begin
                    // idle gap of 0 to 2 cycles before each beat
                    repeat ({$random(seed)} % 3) @(negedge I_clk);
                    rd.data = {word_at(base + 8 * b + 4), word_at(base + 8 * b)};
                    rd.valid = 1'b1;
                    rd.last = (b == `ICACHE_BEATS - 1);
                    @(negedge I_clk);
                    rd = '0;
                end
            end
        end
    end

endmodule

//--- design/icache_top.sv
module icache_top (
    input  logic                  I_clk,
    input  logic                  I_rst,
    // cpu fetch port
    input  icache_pkg::addr_t     cpu_addr,
    input  logic                  cpu_req,
    output logic                  cpu_ready,
    output icache_pkg::word_t     cpu_inst,
    output logic                  cpu_rvalid,
    // memory burst port
    output icache_pkg::addr_t     mem_araddr,
    output logic                  mem_arvalid,
    input  logic                  mem_arready,
    input  icache_pkg::mem_rd_t   mem_rd
);

    // lookup path
    icache_pkg::index_t   lookup_index;
    icache_pkg::tag_t     lookup_tag;
    icache_pkg::way_vec_t hit;
    icache_pkg::way_vec_t victim;

    // data path
    icache_pkg::index_t   rd_index;
    icache_pkg::line_t    rd_line0;
    icache_pkg::line_t    rd_line1;
    // refill write, fans out to both arrays
    icache_pkg::line_wr_t wr;

    ////////////////////
    // arrays
    ////////////////////
    icache_tag_array u_tag (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .victim       (victim),
        .wr           (wr)
    );

    icache_data_array u_data (
        .I_clk    (I_clk),
        .rd_index (rd_index),
        .rd_line0 (rd_line0),
        .rd_line1 (rd_line1),
        .wr       (wr)
    );

    ////////////////////
    // controller
    ////////////////////
    icache_ctrl u_ctrl (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_addr     (cpu_addr),
        .cpu_req      (cpu_req),
        .cpu_ready    (cpu_ready),
        .cpu_inst     (cpu_inst),
        .cpu_rvalid   (cpu_rvalid),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .victim       (victim),
        .rd_index     (rd_index),
        .rd_line0     (rd_line0),
        .rd_line1     (rd_line1),
        .wr           (wr),
        .mem_araddr   (mem_araddr),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_rd       (mem_rd)
    );

endmodule

//--- design/icache_ctrl.sv
`include "icache_macros.svh"

module icache_ctrl (
    input  logic                   I_clk,
    input  logic                   I_rst,
    // cpu fetch port
    input  icache_pkg::addr_t      cpu_addr,
    input  logic                   cpu_req,
    output logic                   cpu_ready,
    output icache_pkg::word_t      cpu_inst,
    output logic                   cpu_rvalid,
    // tag array
    output icache_pkg::index_t     lookup_index,
    output icache_pkg::tag_t       lookup_tag,
    input  icache_pkg::way_vec_t   hit,
    input  icache_pkg::way_vec_t   victim,
    // data array
    output icache_pkg::index_t     rd_index,
    input  icache_pkg::line_t      rd_line0,
    input  icache_pkg::line_t      rd_line1,
    output icache_pkg::line_wr_t   wr,
    // memory port
    output icache_pkg::addr_t      mem_araddr,
    output logic                   mem_arvalid,
    input  logic                   mem_arready,
    input  icache_pkg::mem_rd_t    mem_rd
);

    localparam int LINE_W = `ICACHE_BEATS * `ICACHE_BEAT_BITS;

    icache_pkg::fetch_state_t state_q;
    icache_pkg::fetch_state_t state_d;

    // accepted request and its refill way
    icache_pkg::addr_t    addr_q;
    icache_pkg::way_vec_t victim_q;
    icache_pkg::way_vec_t hit_way_q;
    icache_pkg::offset_t  offset;

    // refill line, beats shifted in from the top
    icache_pkg::line_t line_q;
    icache_pkg::line_t hit_line;
    icache_pkg::line_t src_line;

    logic accept;

    ////////////////////
    // cpu handshake
    ////////////////////
    assign cpu_ready = (state_q == icache_pkg::IDLE) || (state_q == icache_pkg::HIT);
    assign accept = cpu_req && cpu_ready;

    // lookup and read driven straight from the cpu address
    assign lookup_tag = cpu_addr[31 -: `ICACHE_TAG_BITS];
    assign lookup_index = cpu_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign rd_index = lookup_index;

    // latch address, hit way and victim on acceptance
    always_ff @(posedge I_clk) begin
        if (accept) begin
            addr_q <= cpu_addr;
            hit_way_q <= hit;
            victim_q <= victim;
        end
    end

    ////////////////////
    // fetch FSM
    ////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // HIT also takes the next request
            icache_pkg::IDLE, icache_pkg::HIT: begin
                if (!accept) begin
                    state_d = icache_pkg::IDLE;
                end else if (|hit) begin
                    state_d = icache_pkg::HIT;
                end else begin
                    state_d = icache_pkg::MISS;
                end
            end
            icache_pkg::MISS: begin
                if (mem_arready) begin
                    state_d = icache_pkg::RELOAD;
                end
            end
            // gaps in valid just hold here
            icache_pkg::RELOAD: begin
                if (mem_rd.valid && mem_rd.last) begin
                    state_d = icache_pkg::ALLOCATE;
                end
            end
            icache_pkg::ALLOCATE: state_d = icache_pkg::IDLE;
            default: state_d = icache_pkg::IDLE;
        endcase
    end

    ////////////////////
    // memory request
    ////////////////////
    // state decode keeps both stable until arready
    assign mem_arvalid = (state_q == icache_pkg::MISS);
    assign mem_araddr = {addr_q[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};

    // lowest beat first, ends at the bottom after the last shift
    always_ff @(posedge I_clk) begin
        if (state_q == icache_pkg::RELOAD && mem_rd.valid) begin
            line_q <= {mem_rd.data, line_q[LINE_W-1:`ICACHE_BEAT_BITS]};
        end
    end

    // refill write, same cycle as the miss response
    assign wr.en = (state_q == icache_pkg::ALLOCATE);
    assign wr.index = addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign wr.way = victim_q;
    assign wr.tag = addr_q[31 -: `ICACHE_TAG_BITS];
    assign wr.line = line_q;

    ////////////////////
    // word return
    ////////////////////
    assign offset = addr_q[`ICACHE_OFFSET_BITS-1:0];
    assign hit_line = hit_way_q[1] ? rd_line1 : rd_line0;
    // registered array line on a hit, refill line otherwise
    assign src_line = (state_q == icache_pkg::HIT) ? hit_line : line_q;
    assign cpu_inst = src_line[{offset[`ICACHE_OFFSET_BITS-1:2], 5'b0} +: 32];
    assign cpu_rvalid = (state_q == icache_pkg::HIT) || (state_q == icache_pkg::ALLOCATE);

    // request held steady through back-pressure
    assert property (@(posedge I_clk) disable iff (I_rst)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

    // miss response is a single pulse
    assert property (@(posedge I_clk) disable iff (I_rst)
        (state_q == icache_pkg::ALLOCATE) |=> !cpu_rvalid);

endmodule

//--- design/icache_data_array.sv
`include "icache_macros.svh"

module icache_data_array (
    input  logic                  I_clk,
    input  icache_pkg::index_t    rd_index,
    output icache_pkg::line_t     rd_line0,
    output icache_pkg::line_t     rd_line1,
    input  icache_pkg::line_wr_t  wr
);

    ////////////////////
    // line storage
    ////////////////////
    // 64 lines per way
    icache_pkg::line_t line_mem [`ICACHE_WAYS][`ICACHE_SETS];

    // read data registers, both ways at once
    icache_pkg::line_t rd_line_q [`ICACHE_WAYS];

    // full-line write into the chosen way
    always_ff @(posedge I_clk) begin
        if (wr.en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (wr.way[w]) begin
                    line_mem[w][wr.index] <= wr.line;
                end
            end
        end
    end

    ////////////////////
    // synchronous read
    ////////////////////
    // old data on a same-cycle write,
    // the controller never reads a set it is writing
    always_ff @(posedge I_clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            rd_line_q[w] <= line_mem[w][rd_index];
        end
    end

    // one cycle after rd_index
    assign rd_line0 = rd_line_q[0];
    assign rd_line1 = rd_line_q[1];

    // refill way comes from the captured victim
    assert property (@(posedge I_clk) wr.en |-> $onehot(wr.way));

endmodule

//--- design/icache_tag_array.sv
`include "icache_macros.svh"

module icache_tag_array (
    input  logic                   I_clk,
    input  logic                   I_rst,
    input  icache_pkg::index_t     lookup_index,
    input  icache_pkg::tag_t       lookup_tag,
    output icache_pkg::way_vec_t   hit,
    output icache_pkg::way_vec_t   victim,
    input  icache_pkg::line_wr_t   wr
);

    ////////////////////
    // storage
    ////////////////////
    // tags per way and set
    icache_pkg::tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    // valid bits, one vector per way
    logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];
    // valid bits of the looked-up set
    icache_pkg::way_vec_t set_valid;

    // valid bits cleared only on reset
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (wr.en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (wr.way[w]) begin
                    valid_q[w][wr.index] <= 1'b1;
                end
            end
        end
    end

    // tag written into the refilled way
    always_ff @(posedge I_clk) begin
        if (wr.en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (wr.way[w]) begin
                    tag_mem[w][wr.index] <= wr.tag;
                end
            end
        end
    end

    ////////////////////
    // lookup
    ////////////////////
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            set_valid[w] = valid_q[w][lookup_index];
            hit[w] = set_valid[w] && (tag_mem[w][lookup_index] == lookup_tag);
        end
    end

    // way 1 only when way 0 full and way 1 empty
    assign victim[1] = set_valid[0] & ~set_valid[1];
    assign victim[0] = ~victim[1];

    // a tag lives in one way only, refill never duplicates it
    assert property (@(posedge I_clk) disable iff (I_rst) !(&hit));

endmodule

//--- design/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    // address and its fields
    typedef logic [31:0] addr_t;
    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t;

    // payload widths
    typedef logic [31:0] word_t;
    typedef logic [`ICACHE_BEAT_BITS-1:0] beat_t;
    typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;

    // one bit per way, hit and victim
    typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

    // memory read data channel
    typedef struct packed {
        beat_t data;
        logic  valid;
        logic  last;
    } mem_rd_t;

    // refill write, shared by tag and data array
    typedef struct packed {
        logic     en;
        index_t   index;
        way_vec_t way;
        tag_t     tag;
        line_t    line;
    } line_wr_t;

    typedef enum logic [2:0] {IDLE, HIT, MISS, RELOAD, ALLOCATE} fetch_state_t;

endpackage

//--- design/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

////////////////////
// cache geometry
////////////////////
// 4 KB in 32-byte lines
`define ICACHE_LINE_BYTES 32
`define ICACHE_SETS 64
`define ICACHE_WAYS 2

// refill burst shape, 4 x 8 bytes fills one line
`define ICACHE_BEAT_BITS 64
`define ICACHE_BEATS 4

// address fields, tag above index above offset
`define ICACHE_OFFSET_BITS 5
`define ICACHE_INDEX_BITS 6
`define ICACHE_TAG_BITS 21

`endif
